//--- common/float_pkg.sv
package float_pkg;

    // ieee 754 single precision layout
    localparam int float_width = 32;
    localparam int exp_width   = 8;
    localparam int mant_width  = 23;

    // significand with the hidden one in front
    localparam int sig_width  = mant_width + 1;

    // full integer product of two significands
    localparam int prod_width = 2 * sig_width;

    // exponent bias for single precision
    localparam int exp_bias = 127;

    // signed width for the raw exponent sum
    // range is -125 .. 381, so 10 bits with sign is enough
    localparam int exp_calc_width = 10;

    // largest biased exponent that is still finite
    // 255 is reserved for inf / nan
    localparam int exp_max = 254;

    // one add-shift step per multiplier bit
    localparam int mant_cycles = sig_width;

    // down counter for the mantissa loop, holds 0 .. mant_cycles
    localparam int cnt_width = $clog2(mant_cycles + 1);

endpackage

//--- common/exp_result_if.sv
`timescale 1ns/1ps

interface exp_result_if;
    import float_pkg::*;

    // one-cycle strobe, other fields valid with it
    logic                              done;
    // xor of operand signs
    logic                              sign;
    // exp_a + exp_b - bias, may be out of range
    logic signed [exp_calc_width-1:0]  exp_sum;
    // either exponent field was zero
    logic                              zero;

    // exponent path side
    modport src (
        output done,
        output sign,
        output exp_sum,
        output zero
    );

    // normalizer side
    modport dst (
        input done,
        input sign,
        input exp_sum,
        input zero
    );

endinterface

//--- src/float_exp_path.sv
`timescale 1ns/1ps

module float_exp_path (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            req,
    input  logic [float_pkg::float_width-1:0] a,
    input  logic [float_pkg::float_width-1:0] b,
    exp_result_if.src                       res
);
    import float_pkg::*;

    // stage 1 capture of the operand fields
    logic                  pend;
    logic                  sign_q;
    logic [exp_width-1:0]  exp_a_q;
    logic [exp_width-1:0]  exp_b_q;

    // stage 2 arithmetic on the captured fields
    logic signed [exp_calc_width-1:0] sum_calc;

    // zero-extend both fields before the subtract
    assign sum_calc = exp_calc_width'(exp_a_q) + exp_calc_width'(exp_b_q)
                    - exp_calc_width'(exp_bias);

    // strobes only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend     <= 1'b0;
            res.done <= 1'b0;
        end else begin
            pend     <= req;
            // done follows req by two edges
            res.done <= pend;
        end
    end

    // operand fields taken straight from the request words
    always_ff @(posedge clk) begin
        if (req) begin
            sign_q  <= a[float_width-1] ^ b[float_width-1];
            exp_a_q <= a[float_width-2 -: exp_width];
            exp_b_q <= b[float_width-2 -: exp_width];
        end
    end

    // registered result, held until the next request
    always_ff @(posedge clk) begin
        if (pend) begin
            res.sign    <= sign_q;
            res.exp_sum <= sum_calc;
            // denormals count as zero here
            res.zero    <= (exp_a_q == '0) || (exp_b_q == '0);
        end
    end

endmodule

//--- src/float_mant_mul.sv
`timescale 1ns/1ps

module float_mant_mul (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              req,
    input  logic [float_pkg::float_width-1:0] a,
    input  logic [float_pkg::float_width-1:0] b,
    output logic                              prod_done,
    output logic [float_pkg::prod_width-1:0]  product
);
    import float_pkg::*;

    // loop control
    logic                  busy;
    logic [cnt_width-1:0]  cnt;

    // multiplicand shifts left, multiplier shifts right
    logic [prod_width-1:0] mcand;
    logic [sig_width-1:0]  mplier;
    logic [prod_width-1:0] acc;

    assign product = acc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            cnt       <= '0;
            prod_done <= 1'b0;
        end else begin
            prod_done <= 1'b0;
            if (req) begin
                // a new request always restarts the loop
                busy <= 1'b1;
                cnt  <= cnt_width'(mant_cycles);
            end else if (busy) begin
                cnt <= cnt - 1'b1;
                // last step happens on this edge
                if (cnt == cnt_width'(1)) begin
                    busy      <= 1'b0;
                    prod_done <= 1'b1;
                end
            end
        end
    end

    // datapath, one add-shift per busy cycle
    always_ff @(posedge clk) begin
        if (req) begin
            // hidden one goes back in front of the fraction
            mcand  <= prod_width'({1'b1, a[mant_width-1:0]});
            mplier <= {1'b1, b[mant_width-1:0]};
            acc    <= '0;
        end else if (busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

endmodule

//--- src/float_normalize.sv
`timescale 1ns/1ps

module float_normalize (
    input  logic                              clk,
    input  logic                              rst_n,
    exp_result_if.dst                         res,
    input  logic                              prod_done,
    input  logic [float_pkg::prod_width-1:0]  product,
    output logic                              ack,
    output logic [float_pkg::float_width-1:0] out
);
    import float_pkg::*;

    // exponent result waiting for the mantissa
    logic                              wait_prod;
    logic                              lat_sign;
    logic signed [exp_calc_width-1:0]  lat_exp;

    // normalized fields
    logic signed [exp_calc_width-1:0]  exp_fin;
    logic [mant_width-1:0]             mant_fin;
    logic [float_width-1:0]            norm_word;

    // product of two values in [1,2) lies in [1,4)
    // so at most one bit of shift is needed
    always_comb begin
        if (product[prod_width-1]) begin
            mant_fin = product[prod_width-2 -: mant_width];
            exp_fin  = lat_exp + exp_calc_width'(1);
        end else begin
            mant_fin = product[prod_width-3 -: mant_width];
            exp_fin  = lat_exp;
        end
    end

    // range check after the carry has been added
    always_comb begin
        if (exp_fin > exp_max) begin
            // overflow saturates to inf
            norm_word = {lat_sign, {exp_width{1'b1}}, {mant_width{1'b0}}};
        end else if (exp_fin < 1) begin
            // underflow flushes to zero
            norm_word = {lat_sign, {(float_width-1){1'b0}}};
        end else begin
            norm_word = {lat_sign, exp_fin[exp_width-1:0], mant_fin};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_prod <= 1'b0;
            ack       <= 1'b0;
            out       <= '0;
        end else begin
            ack <= 1'b0;
            if (res.done && res.zero) begin
                // short path, the running multiply is ignored
                out       <= {res.sign, {(float_width-1){1'b0}}};
                ack       <= 1'b1;
                wait_prod <= 1'b0;
            end else if (res.done) begin
                wait_prod <= 1'b1;
            end else if (wait_prod && prod_done) begin
                out       <= norm_word;
                ack       <= 1'b1;
                wait_prod <= 1'b0;
            end
        end
    end

    // latch sign and exponent at the strobe
    always_ff @(posedge clk) begin
        if (res.done) begin
            lat_sign <= res.sign;
            lat_exp  <= res.exp_sum;
        end
    end

endmodule

//--- src/float_mul_pipeline.sv
`timescale 1ns/1ps

module float_mul_pipeline (
    input  logic                              clk,
    input  logic                              rst_n,
    // one-cycle request with both operands
    input  logic                              req,
    input  logic [float_pkg::float_width-1:0] a,
    input  logic [float_pkg::float_width-1:0] b,
    // one-cycle done pulse, out held until the next one
    output logic                              ack,
    output logic [float_pkg::float_width-1:0] out
);

    // mantissa result, two signals so plain wires
    logic                             prod_done;
    logic [float_pkg::prod_width-1:0] product;

    // exponent path to normalizer
    exp_result_if exp_res_i ();

    // sign, exponent sum, zero detect
    float_exp_path exp_path_i (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .a     (a),
        .b     (b),
        .res   (exp_res_i.src)
    );

    // 24-step shift-add significand product
    float_mant_mul mant_mul_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .a         (a),
        .b         (b),
        .prod_done (prod_done),
        .product   (product)
    );

    // merge both paths and drive the result
    float_normalize normalize_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .res       (exp_res_i.dst),
        .prod_done (prod_done),
        .product   (product),
        .ack       (ack),
        .out       (out)
    );

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 8 ns period, 4 ns per half
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held low for three rising edges
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- sim/float_mul_properties.sv
`timescale 1ns/1ps

module float_mul_properties (
    input logic                              clk,
    input logic                              rst_n,
    input logic                              req,
    input logic [float_pkg::float_width-1:0] a,
    input logic [float_pkg::float_width-1:0] b,
    input logic                              ack,
    input logic [float_pkg::float_width-1:0] out
);
    import float_pkg::*;

    // nonzero once any check has failed, watched by the testbench top
    int unsigned fail_count = 0;

    // operands of the operation in flight
    logic [float_width-1:0] op_a;
    logic [float_width-1:0] op_b;
    logic                   pending;
    logic                   seen_req;
    // edges since the one that sampled req
    int unsigned            age;

    // expected result and latency for the latched operands
    logic [float_width-1:0] exp_word;
    int unsigned            exp_latency;

    // reference product: hidden one, integer multiply, one-bit normalize, truncate
    function automatic logic [float_width-1:0] model_product(
        input logic [float_width-1:0] x,
        input logic [float_width-1:0] y
    );
        logic                  sign;
        logic [exp_width-1:0]  ex;
        logic [exp_width-1:0]  ey;
        logic [prod_width-1:0] p;
        logic [mant_width-1:0] m;
        int                    e;
        sign = x[float_width-1] ^ y[float_width-1];
        ex   = x[float_width-2 -: exp_width];
        ey   = y[float_width-2 -: exp_width];
        // zero or denormal operand gives signed zero
        if (ex == '0 || ey == '0) begin
            return {sign, {(float_width-1){1'b0}}};
        end
        p = prod_width'({1'b1, x[mant_width-1:0]}) * prod_width'({1'b1, y[mant_width-1:0]});
        e = int'(ex) + int'(ey) - exp_bias;
        if (p[prod_width-1]) begin
            m = p[prod_width-2 -: mant_width];
            e = e + 1;
        end else begin
            m = p[prod_width-3 -: mant_width];
        end
        if (e > exp_max) begin
            return {sign, {exp_width{1'b1}}, {mant_width{1'b0}}};
        end
        if (e < 1) begin
            return {sign, {(float_width-1){1'b0}}};
        end
        return {sign, e[exp_width-1:0], m};
    endfunction

    always_comb begin
        exp_word = model_product(op_a, op_b);
        // short path for zero fields, else the full mantissa loop plus one
        if (op_a[float_width-2 -: exp_width] == '0 || op_b[float_width-2 -: exp_width] == '0) begin
            exp_latency = 2;
        end else begin
            exp_latency = mant_cycles + 1;
        end
    end

    // track the operation in flight
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_a     <= '0;
            op_b     <= '0;
            pending  <= 1'b0;
            seen_req <= 1'b0;
            age      <= 0;
        end else if (req) begin
            op_a     <= a;
            op_b     <= b;
            pending  <= 1'b1;
            seen_req <= 1'b1;
            age      <= 0;
        end else if (ack) begin
            pending <= 1'b0;
        end else if (pending) begin
            age <= age + 1;
        end
    end

    // quiet outputs between reset and the first request
    idle_chk: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_req |-> (!ack && out == '0))
        else begin
            fail_count = fail_count + 1;
            $error("FAILED out before first req: ack %h out %h", $sampled(ack), $sampled(out));
        end

    // ack only at the expected latency
    latency_chk: assert property (@(posedge clk) disable iff (!rst_n)
        ack |-> (pending && age == exp_latency))
        else begin
            fail_count = fail_count + 1;
            $error("FAILED ack: latency %h expected %h", $sampled(age), $sampled(exp_latency));
        end

    // ack must not go missing
    ack_due_chk: assert property (@(posedge clk) disable iff (!rst_n)
        (pending && !req && age == exp_latency) |-> ack)
        else begin
            fail_count = fail_count + 1;
            $error("ack did not arrive when the operation was due");
        end

    result_chk: assert property (@(posedge clk) disable iff (!rst_n)
        ack |-> (out == exp_word))
        else begin
            fail_count = fail_count + 1;
            $error("FAILED out: got %h expected %h (a %h b %h)",
                   $sampled(out), $sampled(exp_word), $sampled(op_a), $sampled(op_b));
        end

    // one-cycle pulse
    pulse_chk: assert property (@(posedge clk) disable iff (!rst_n)
        ack |-> !$past(ack))
        else begin
            fail_count = fail_count + 1;
            $error("FAILED ack: high %h for two cycles in a row", $sampled(ack));
        end

    // result holds between pulses
    hold_chk: assert property (@(posedge clk) disable iff (!rst_n)
        !ack |-> $stable(out))
        else begin
            fail_count = fail_count + 1;
            $error("FAILED out: changed from %h to %h without ack",
                   $past(out), $sampled(out));
        end

endmodule

// checks ride along with every multiplier top level
bind float_mul_pipeline float_mul_properties props_i (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .a     (a),
    .b     (b),
    .ack   (ack),
    .out   (out)
);

//--- sim/tb_float_mul.sv
`timescale 1ns/1ps

module tb_float_mul;
    import float_pkg::*;

    logic                   clk;
    logic                   rst_n;
    logic                   req;
    logic [float_width-1:0] a;
    logic [float_width-1:0] b;
    logic                   ack;
    logic [float_width-1:0] out;

    int          seed = 7;
    int unsigned cycle_count = 0;
    // 60 operations at up to 30 cycles each, plus reset
    int unsigned cycle_limit = 60 * 30 + 3;

    tb_clock_gen clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    float_mul_pipeline dut_i (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .a     (a),
        .b     (b),
        .ack   (ack),
        .out   (out)
    );

    // random normal operand, biased exponent 64..190 keeps the product finite
    function automatic logic [float_width-1:0] normal_operand(input int r_word, input int r_exp);
        logic [exp_width-1:0] e;
        e = exp_width'(64 + ($unsigned(r_exp) % 127));
        return {r_word[float_width-1], e, r_word[mant_width-1:0]};
    endfunction

    // one-cycle request, then wait for the ack pulse
    task automatic multiply(input logic [float_width-1:0] op_a, input logic [float_width-1:0] op_b);
        @(posedge clk);
        req <= 1'b1;
        a   <= op_a;
        b   <= op_b;
        @(posedge clk);
        req <= 1'b0;
        do begin
            @(posedge clk);
        end while (ack !== 1'b1);
    endtask

    task automatic multiply_random(input int count);
        int r_a;
        int r_b;
        int e_a;
        int e_b;
        for (int i = 0; i < count; i++) begin
            r_a = $random(seed);
            e_a = $random(seed);
            r_b = $random(seed);
            e_b = $random(seed);
            multiply(normal_operand(r_a, e_a), normal_operand(r_b, e_b));
        end
    endtask

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Test failed");
            $fatal(1, "timeout after %0d cycles with operations still running", cycle_count);
        end
    end

    // stop at the first failed property
    always @(posedge clk) begin
        if (dut_i.props_i.fail_count != 0) begin
            $display("Test failed");
            $fatal(1, "a property check on the multiplier failed");
        end
    end

    initial begin
        req = 1'b0;
        a   = '0;
        b   = '0;
        wait (rst_n === 1'b1);
        // idle cycles so the post-reset outputs get checked
        repeat (2) @(posedge clk);
        // 1.9 * 1.9, 2 * 2.3, 200 * 100
        multiply(32'h3ff33333, 32'h3ff33333);
        multiply(32'h40000000, 32'h40133333);
        multiply(32'h43480000, 32'h42c80000);
        // no carry and carry into the top product bit
        multiply(32'h3f800000, 32'h3f800000);
        multiply(32'h3fc00000, 32'h3fc00000);
        // sign combinations
        multiply(32'hbff33333, 32'h3ff33333);
        multiply(32'h3ff33333, 32'hbff33333);
        multiply(32'hbff33333, 32'hbff33333);
        multiply(32'hc0000000, 32'h40133333);
        // zero and denormal operands
        multiply(32'h00000000, 32'h3ff33333);
        multiply(32'h80000000, 32'h40133333);
        multiply(32'h3ff33333, 32'h80000000);
        multiply(32'h00000000, 32'h00000000);
        multiply(32'h00000001, 32'h3f800000);
        // overflow to signed infinity
        multiply(32'h7f000000, 32'h7f000000);
        multiply(32'hff000000, 32'h40000000);
        multiply(32'h7f7fffff, 32'h3fc00000);
        // underflow, last one lands on exponent 1 through the carry
        multiply(32'h00800000, 32'h00800000);
        multiply(32'h80800000, 32'h3f000000);
        multiply(32'h00ffffff, 32'h3f7fffff);
        multiply_random(40);
        // let the last checks settle
        repeat (3) @(posedge clk);
        if (dut_i.props_i.fail_count == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "property checks failed during the run");
        end
    end

endmodule

//--- verilog.f
common/float_pkg.sv
common/exp_result_if.sv
src/float_exp_path.sv
src/float_mant_mul.sv
src/float_normalize.sv
src/float_mul_pipeline.sv
sim/tb_clock_gen.sv
sim/float_mul_properties.sv
sim/tb_float_mul.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_float_mul
RTL_TOP   ?= float_mul_pipeline
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
RUN_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
